//--- Makefile
# Verilator build and run of the tusca testbench

VERILATOR ?= verilator
TOP       ?= tb_tusca
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j $(JOBS)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build $(TOP) with Verilator and run it"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR JOBS VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- common/tusca_pkg.sv
/*
 * Tusca shared types: FSM states of the control unit and the
 * DHT11 master, and the temperature level
 */
package tusca_pkg;

  typedef enum logic [2:0] {
    uc_inicial,
    uc_medir,
    uc_transmitir,
    uc_espera,
    uc_config
  } uc_state_t;

  typedef enum logic [2:0] {
    dht_ocioso,
    dht_pulso_inicio,
    dht_resposta,
    dht_bit_baixo,
    dht_bit_alto,
    dht_verifica
  } dht_state_t;

  typedef logic [2:0] nivel_t;  // 0 to 4

endpackage

//--- common/tusca_settings.svh
/*
 * Tusca climate controller timing and reset defaults,
 * with cycle counts scaled down for short simulations
 */
`ifndef TUSCA_SETTINGS_SVH
`define TUSCA_SETTINGS_SVH

`define TUSCA_UART_BIT_CYCLES   16   // Clock cycles per UART bit
`define TUSCA_DHT_START_CYCLES  40   // Master low pulse on the sensor bus
`define TUSCA_DHT_BIT_THRESHOLD 12   // Longer high phase means a 1 bit
`define TUSCA_DHT_TIMEOUT       200  // Cycles without a bus edge
`define TUSCA_DELAY_CYCLES      300  // Wait between measurements
`define TUSCA_PWM_PERIOD        64   // Fan PWM period

`define TUSCA_LIM_TEMP1   20
`define TUSCA_LIM_TEMP2   25
`define TUSCA_LIM_TEMP3   30
`define TUSCA_LIM_TEMP4   35
`define TUSCA_LIM_UMIDADE 70

`endif

//--- dht11/dht11_interface.sv
/*
 * DHT11 single-wire master: start pulse, response handshake,
 * 40-bit read by high phase length, checksum and timeout
 */
`timescale 1ns/1ps
`include "tusca_settings.svh"

module dht11_interface import tusca_pkg::*; (
  input  logic       clock,
  input  logic       reset,
  input  logic       medir_dht11,
  inout  wire        dht_bus,
  output logic       pronto_medida,
  output logic       erro_medida,
  output logic [7:0] temperatura,
  output logic [7:0] umidade
);

  localparam int unsigned cnt_w = $clog2(`TUSCA_DHT_TIMEOUT + 1);
  localparam logic [cnt_w-1:0] inicio_fim  = cnt_w'(`TUSCA_DHT_START_CYCLES - 1);
  localparam logic [cnt_w-1:0] limiar_um   = cnt_w'(`TUSCA_DHT_BIT_THRESHOLD);
  localparam logic [cnt_w-1:0] timeout_fim = cnt_w'(`TUSCA_DHT_TIMEOUT - 1);

  dht_state_t       estado;
  logic             puxa_baixo;
  logic [1:0]       bus_sinc;
  logic             bus_q;
  logic             subida;
  logic             descida;
  logic             aguardando;
  logic             resposta_baixa;  // Sensor response low phase seen
  logic [cnt_w-1:0] conta;
  logic [5:0]       bits;
  logic [39:0]      dados;
  logic [7:0]       soma;

  assign dht_bus = puxa_baixo ? 1'b0 : 1'bz;  // Open drain

  assign subida     = bus_sinc[1] & ~bus_q;
  assign descida    = ~bus_sinc[1] & bus_q;
  assign aguardando = (estado == dht_resposta) || (estado == dht_bit_baixo) ||
                      (estado == dht_bit_alto);
  // Humidity and temperature bytes, integer and decimal
  assign soma = dados[39:32] + dados[31:24] + dados[23:16] + dados[15:8];

  always_ff @(posedge clock) begin
    if (estado == dht_bit_alto && descida) begin
      dados <= {dados[38:0], conta > limiar_um};
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      estado         <= dht_ocioso;
      puxa_baixo     <= 1'b0;
      bus_sinc       <= 2'b11;
      bus_q          <= 1'b1;
      resposta_baixa <= 1'b0;
      conta          <= '0;
      bits           <= '0;
      pronto_medida  <= 1'b0;
      erro_medida    <= 1'b0;
      temperatura    <= '0;
      umidade        <= '0;
    end else begin
      bus_sinc      <= {bus_sinc[0], dht_bus};
      bus_q         <= bus_sinc[1];
      pronto_medida <= 1'b0;
      erro_medida   <= 1'b0;
      conta         <= conta + 1'b1;
      if (aguardando && (subida || descida)) begin
        conta <= '0;                  // Phase length restarts on every edge
      end
      if (aguardando && conta == timeout_fim) begin
        estado        <= dht_ocioso;
        pronto_medida <= 1'b1;
        erro_medida   <= 1'b1;
      end else begin
        case (estado)
          dht_ocioso: begin
            conta <= '0;
            if (medir_dht11) begin
              estado     <= dht_pulso_inicio;
              puxa_baixo <= 1'b1;
            end
          end
          dht_pulso_inicio: begin
            if (conta == inicio_fim) begin
              estado         <= dht_resposta;
              puxa_baixo     <= 1'b0;
              conta          <= '0;
              bits           <= '0;
              resposta_baixa <= 1'b0;
            end
          end
          dht_resposta: begin
            if (descida) begin
              if (resposta_baixa) begin
                estado <= dht_bit_baixo;  // Low phase of bit 0
              end else begin
                resposta_baixa <= 1'b1;
              end
            end
          end
          dht_bit_baixo: begin
            if (subida) begin
              estado <= dht_bit_alto;
            end
          end
          dht_bit_alto: begin
            if (descida) begin
              bits   <= bits + 1'b1;
              estado <= (bits == 6'd39) ? dht_verifica : dht_bit_baixo;
            end
          end
          dht_verifica: begin
            estado        <= dht_ocioso;
            pronto_medida <= 1'b1;
            if (soma == dados[7:0]) begin
              umidade     <= dados[39:32];
              temperatura <= dados[23:16];
            end else begin
              erro_medida <= 1'b1;
            end
          end
          default: estado <= dht_ocioso;
        endcase
      end
    end
  end

  a_pronto_pulso: assert property (@(posedge clock) disable iff (reset)
    pronto_medida |=> !pronto_medida);

endmodule

//--- rtl/climate_actuator.sv
/*
 * Climate actuators: temperature level against four limits,
 * fan PWM with duty set by the level, humidity relay
 */
`timescale 1ns/1ps
`include "tusca_settings.svh"

module climate_actuator import tusca_pkg::*; (
  input  logic       clock,
  input  logic       reset,
  input  logic [7:0] temperatura,
  input  logic [7:0] umidade,
  input  logic [7:0] lim_temp1,
  input  logic [7:0] lim_temp2,
  input  logic [7:0] lim_temp3,
  input  logic [7:0] lim_temp4,
  input  logic [7:0] lim_umidade,
  output nivel_t     nivel,
  output logic       rele,
  output logic       pwm_ventoinha
);

  localparam int unsigned pwm_w = $clog2(`TUSCA_PWM_PERIOD);
  localparam logic [pwm_w-1:0] periodo_fim = pwm_w'(`TUSCA_PWM_PERIOD - 1);
  localparam int unsigned quarto = `TUSCA_PWM_PERIOD / 4;

  logic [pwm_w-1:0] conta;
  logic [pwm_w:0]   duty;     // Up to the full period
  nivel_t           nivel_prox;

  assign nivel_prox = nivel_t'(temperatura >= lim_temp1) + nivel_t'(temperatura >= lim_temp2) +
                      nivel_t'(temperatura >= lim_temp3) + nivel_t'(temperatura >= lim_temp4);

  always_ff @(posedge clock) begin
    if (reset) begin
      nivel         <= '0;
      rele          <= 1'b0;
      conta         <= '0;
      duty          <= '0;
      pwm_ventoinha <= 1'b0;
    end else begin
      nivel         <= nivel_prox;
      rele          <= (umidade >= lim_umidade);
      pwm_ventoinha <= ({1'b0, conta} < duty);
      if (conta == periodo_fim) begin
        conta <= '0;
        duty  <= (pwm_w + 1)'(nivel * quarto);  // New duty at period start
      end else begin
        conta <= conta + 1'b1;
      end
    end
  end

  a_nivel_max: assert property (@(posedge clock) disable iff (reset)
    nivel <= 3'd4);

endmodule

//--- rtl/config_manager.sv
/*
 * Threshold config manager: collects a six-byte frame, checks
 * sum and limit order, then commits or flags the error
 */
`timescale 1ns/1ps
`include "tusca_settings.svh"

module config_manager (
  input  logic       clock,
  input  logic       reset,
  input  logic       receber_config,
  input  logic       byte_valid,
  input  logic [7:0] data,
  output logic       pronto_config,
  output logic       erro_config,
  output logic [7:0] lim_temp1,
  output logic [7:0] lim_temp2,
  output logic [7:0] lim_temp3,
  output logic [7:0] lim_temp4,
  output logic [7:0] lim_umidade
);

  logic [7:0] quadro [0:4];
  logic [2:0] indice;
  logic [7:0] soma;
  logic       quadro_ok;

  // data holds the checksum byte when indice is 5
  assign quadro_ok = (soma == data) && (quadro[0] < quadro[1]) &&
                     (quadro[1] < quadro[2]) && (quadro[2] < quadro[3]);

  always_ff @(posedge clock) begin
    if (receber_config && byte_valid && indice != 3'd5) begin
      quadro[indice] <= data;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      indice        <= '0;
      soma          <= '0;
      pronto_config <= 1'b0;
      erro_config   <= 1'b0;
      lim_temp1     <= 8'(`TUSCA_LIM_TEMP1);
      lim_temp2     <= 8'(`TUSCA_LIM_TEMP2);
      lim_temp3     <= 8'(`TUSCA_LIM_TEMP3);
      lim_temp4     <= 8'(`TUSCA_LIM_TEMP4);
      lim_umidade   <= 8'(`TUSCA_LIM_UMIDADE);
    end else begin
      pronto_config <= 1'b0;
      if (!receber_config) begin
        indice <= '0;                 // Partial frame is dropped
        soma   <= '0;
      end else if (byte_valid) begin
        if (indice == 3'd5) begin
          indice        <= '0;
          soma          <= '0;
          pronto_config <= 1'b1;
          erro_config   <= !quadro_ok;
          if (quadro_ok) begin
            lim_temp1   <= quadro[0];
            lim_temp2   <= quadro[1];
            lim_temp3   <= quadro[2];
            lim_temp4   <= quadro[3];
            lim_umidade <= quadro[4];
          end
        end else begin
          indice <= indice + 1'b1;
          soma   <= soma + data;
        end
      end
    end
  end

endmodule

//--- rtl/tusca.sv
/*
 * Tusca climate controller top level: control unit, DHT11 master,
 * config receiver and manager, actuators and measurement sender
 */
`timescale 1ns/1ps

module tusca import tusca_pkg::*; (
  input  logic clock,
  input  logic reset,
  input  logic start,
  input  logic definir_config,
  input  logic cancelar_definir_config,
  input  logic rx_serial_config,
  inout  wire  dht_bus,
  output logic erro_config,
  output logic rele,
  output logic pwm_ventoinha,
  output logic tx_serial,
  output logic esperando_config
);

  logic       s_medir_dht11;
  logic       s_pronto_medida;
  logic       s_erro_medida;
  logic       s_transmite_medida;
  logic       s_pronto_transmissao_medida;
  logic       s_receber_config;
  logic       s_pronto_config;
  logic       s_byte_valid;
  logic [7:0] s_byte_config;
  logic [7:0] s_temperatura;
  logic [7:0] s_umidade;
  logic [7:0] s_lim_temp1;
  logic [7:0] s_lim_temp2;
  logic [7:0] s_lim_temp3;
  logic [7:0] s_lim_temp4;
  logic [7:0] s_lim_umidade;
  nivel_t     s_nivel;

  tusca_uc uc (
    .clock(clock),
    .reset(reset),
    .start(start),
    .definir_config(definir_config),
    .cancelar_definir_config(cancelar_definir_config),
    .pronto_medida(s_pronto_medida),
    .pronto_transmissao_medida(s_pronto_transmissao_medida),
    .pronto_config(s_pronto_config),
    .medir_dht11(s_medir_dht11),
    .transmite_medida(s_transmite_medida),
    .receber_config(s_receber_config),
    .esperando_config(esperando_config)
  );

  dht11_interface dht (
    .clock(clock),
    .reset(reset),
    .medir_dht11(s_medir_dht11),
    .dht_bus(dht_bus),
    .pronto_medida(s_pronto_medida),
    .erro_medida(s_erro_medida),
    .temperatura(s_temperatura),
    .umidade(s_umidade)
  );

  uart_rx rx_config (
    .clock(clock),
    .reset(reset),
    .rx(rx_serial_config),
    .enable(s_receber_config),
    .byte_valid(s_byte_valid),
    .data(s_byte_config)
  );

  config_manager cfg (
    .clock(clock),
    .reset(reset),
    .receber_config(s_receber_config),
    .byte_valid(s_byte_valid),
    .data(s_byte_config),
    .pronto_config(s_pronto_config),
    .erro_config(erro_config),
    .lim_temp1(s_lim_temp1),
    .lim_temp2(s_lim_temp2),
    .lim_temp3(s_lim_temp3),
    .lim_temp4(s_lim_temp4),
    .lim_umidade(s_lim_umidade)
  );

  climate_actuator atuador (
    .clock(clock),
    .reset(reset),
    .temperatura(s_temperatura),
    .umidade(s_umidade),
    .lim_temp1(s_lim_temp1),
    .lim_temp2(s_lim_temp2),
    .lim_temp3(s_lim_temp3),
    .lim_temp4(s_lim_temp4),
    .lim_umidade(s_lim_umidade),
    .nivel(s_nivel),
    .rele(rele),
    .pwm_ventoinha(pwm_ventoinha)
  );

  measurement_sender tx_medida (
    .clock(clock),
    .reset(reset),
    .transmite_medida(s_transmite_medida),
    .erro_medida(s_erro_medida),
    .temperatura(s_temperatura),
    .umidade(s_umidade),
    .nivel(s_nivel),
    .tx_serial(tx_serial),
    .pronto_transmissao_medida(s_pronto_transmissao_medida)
  );

endmodule

//--- rtl/tusca_uc.sv
/*
 * Tusca control unit: measure, transmit and wait cycle, with a
 * config state entered from the wait state
 */
`timescale 1ns/1ps
`include "tusca_settings.svh"

module tusca_uc import tusca_pkg::*; (
  input  logic clock,
  input  logic reset,
  input  logic start,
  input  logic definir_config,
  input  logic cancelar_definir_config,
  input  logic pronto_medida,
  input  logic pronto_transmissao_medida,
  input  logic pronto_config,
  output logic medir_dht11,
  output logic transmite_medida,
  output logic receber_config,
  output logic esperando_config
);

  localparam int unsigned conta_w = $clog2(`TUSCA_DELAY_CYCLES);
  localparam logic [conta_w-1:0] conta_fim = conta_w'(`TUSCA_DELAY_CYCLES - 1);

  uc_state_t          estado;
  logic [conta_w-1:0] conta;
  logic [2:0]         entradas_q;   // start, definir, cancelar
  logic [2:0]         entradas_qq;
  logic [2:0]         bordas;

  assign bordas = entradas_q & ~entradas_qq;

  assign receber_config   = (estado == uc_config);
  assign esperando_config = (estado == uc_config);

  always_ff @(posedge clock) begin
    if (reset) begin
      estado           <= uc_inicial;
      conta            <= '0;
      entradas_q       <= '0;
      entradas_qq      <= '0;
      medir_dht11      <= 1'b0;
      transmite_medida <= 1'b0;
    end else begin
      entradas_q       <= {start, definir_config, cancelar_definir_config};
      entradas_qq      <= entradas_q;
      medir_dht11      <= 1'b0;
      transmite_medida <= 1'b0;
      case (estado)
        uc_inicial: begin
          if (bordas[2]) begin
            estado      <= uc_medir;
            medir_dht11 <= 1'b1;
          end
        end
        uc_medir: begin
          if (pronto_medida) begin
            estado           <= uc_transmitir;
            transmite_medida <= 1'b1;
          end
        end
        uc_transmitir: begin
          if (pronto_transmissao_medida) begin
            estado <= uc_espera;
            conta  <= '0;
          end
        end
        uc_espera: begin
          conta <= conta + 1'b1;
          if (bordas[1]) begin
            estado <= uc_config;      // Config wins over the next measurement
          end else if (conta == conta_fim) begin
            estado      <= uc_medir;
            medir_dht11 <= 1'b1;
          end
        end
        uc_config: begin
          if (pronto_config || bordas[0]) begin
            estado <= uc_espera;
            conta  <= '0;
          end
        end
        default: estado <= uc_inicial;
      endcase
    end
  end

  a_pulsos_exclusivos: assert property (@(posedge clock) disable iff (reset)
    !(medir_dht11 && transmite_medida));

endmodule

//--- serial/measurement_sender.sv
/*
 * 8N1 measurement transmitter: temperature, humidity and level
 * frame, or the single byte 0xEE after a failed reading
 */
`timescale 1ns/1ps
`include "tusca_settings.svh"

module measurement_sender import tusca_pkg::*; (
  input  logic       clock,
  input  logic       reset,
  input  logic       transmite_medida,
  input  logic       erro_medida,
  input  logic [7:0] temperatura,
  input  logic [7:0] umidade,
  input  nivel_t     nivel,
  output logic       tx_serial,
  output logic       pronto_transmissao_medida
);

  localparam int unsigned cnt_w = $clog2(`TUSCA_UART_BIT_CYCLES);
  localparam logic [cnt_w-1:0] bit_fim = cnt_w'(`TUSCA_UART_BIT_CYCLES - 1);

  logic             ocupado;
  logic             erro_pendente;
  logic [23:0]      quadro;
  logic [1:0]       byte_idx;
  logic [1:0]       ultimo_byte;
  logic [3:0]       bit_idx;   // Bit on the line, 0 start and 9 stop
  logic [cnt_w-1:0] conta;

  always_ff @(posedge clock) begin
    if (!ocupado && transmite_medida) begin
      quadro <= erro_pendente ? 24'h0000EE : {5'b0, nivel, umidade, temperatura};
    end else if (ocupado && conta == bit_fim && bit_idx == 4'd9) begin
      quadro <= quadro >> 8;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      ocupado                   <= 1'b0;
      erro_pendente             <= 1'b0;
      byte_idx                  <= '0;
      ultimo_byte               <= '0;
      bit_idx                   <= '0;
      conta                     <= '0;
      tx_serial                 <= 1'b1;
      pronto_transmissao_medida <= 1'b0;
    end else begin
      pronto_transmissao_medida <= 1'b0;
      if (erro_medida) begin
        erro_pendente <= 1'b1;
      end
      if (!ocupado) begin
        if (transmite_medida) begin
          ocupado       <= 1'b1;
          erro_pendente <= 1'b0;
          ultimo_byte   <= erro_pendente ? 2'd0 : 2'd2;
          byte_idx      <= '0;
          bit_idx       <= '0;
          conta         <= '0;
          tx_serial     <= 1'b0;
        end
      end else if (conta == bit_fim) begin
        conta <= '0;
        if (bit_idx == 4'd9) begin
          if (byte_idx == ultimo_byte) begin
            ocupado                   <= 1'b0;
            pronto_transmissao_medida <= 1'b1;
          end else begin
            byte_idx  <= byte_idx + 1'b1;
            bit_idx   <= '0;
            tx_serial <= 1'b0;
          end
        end else begin
          bit_idx   <= bit_idx + 1'b1;
          tx_serial <= (bit_idx == 4'd8) ? 1'b1 : quadro[bit_idx[2:0]];
        end
      end else begin
        conta <= conta + 1'b1;
      end
    end
  end

endmodule

//--- serial/uart_rx.sv
/*
 * 8N1 UART receiver, samples at mid-bit and gives one byte
 * per byte_valid pulse while enabled
 */
`timescale 1ns/1ps
`include "tusca_settings.svh"

module uart_rx (
  input  logic       clock,
  input  logic       reset,
  input  logic       rx,
  input  logic       enable,
  output logic       byte_valid,
  output logic [7:0] data
);

  localparam int unsigned cnt_w = $clog2(`TUSCA_UART_BIT_CYCLES);
  localparam logic [cnt_w-1:0] bit_fim  = cnt_w'(`TUSCA_UART_BIT_CYCLES - 1);
  localparam logic [cnt_w-1:0] meio_bit = cnt_w'(`TUSCA_UART_BIT_CYCLES / 2 - 1);

  logic [1:0]       rx_sinc;
  logic             ocupado;
  logic [cnt_w-1:0] conta;
  logic [3:0]       indice;   // 0 start, 1 to 8 data, 9 stop

  always_ff @(posedge clock) begin
    if (ocupado && conta == meio_bit && indice >= 4'd1 && indice <= 4'd8) begin
      data <= {rx_sinc[1], data[7:1]};  // LSB first
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      rx_sinc    <= 2'b11;
      ocupado    <= 1'b0;
      conta      <= '0;
      indice     <= '0;
      byte_valid <= 1'b0;
    end else begin
      rx_sinc    <= {rx_sinc[0], rx};
      byte_valid <= 1'b0;
      if (!enable) begin
        ocupado <= 1'b0;
      end else if (!ocupado) begin
        if (!rx_sinc[1]) begin
          ocupado <= 1'b1;
          conta   <= '0;
          indice  <= '0;
        end
      end else begin
        conta <= (conta == bit_fim) ? '0 : conta + 1'b1;
        if (conta == bit_fim) begin
          indice <= indice + 1'b1;
        end
        if (conta == meio_bit) begin
          if (indice == 4'd0 && rx_sinc[1]) begin
            ocupado <= 1'b0;            // Glitch, not a start bit
          end
          if (indice == 4'd9) begin
            ocupado    <= 1'b0;
            byte_valid <= rx_sinc[1];   // Framing error drops the byte
          end
        end
      end
    end
  end

endmodule

//--- tests/tb_tusca.sv
/*
 * Tusca testbench: DHT11 sensor model, config UART driver, tx_serial
 * monitor, reference model of frames and actuators
 */
`timescale 1ns/1ps
`include "tusca_settings.svh"

module tb_tusca import tusca_pkg::*; ();

  localparam int bit_cycles      = `TUSCA_UART_BIT_CYCLES;
  localparam int mode_good       = 0;
  localparam int mode_bad_sum    = 1;
  localparam int mode_silent     = 2;
  localparam int sensor_cycles   = `TUSCA_DHT_START_CYCLES + `TUSCA_DHT_TIMEOUT + 40 * 25 + 30;
  localparam int frame_cycles    = 90 * bit_cycles;  // Config frame plus measurement frame
  localparam int watchdog_cycles = 40 * (`TUSCA_DELAY_CYCLES + frame_cycles + sensor_cycles);

  logic clock;
  logic reset;
  logic start;
  logic definir_config;
  logic cancelar_definir_config;
  logic rx_serial_config;
  logic erro_config;
  logic rele;
  logic pwm_ventoinha;
  logic tx_serial;
  logic esperando_config;
  logic sensor_low;
  tri1  dht_bus;

  logic [39:0] sensor_word_q[$];
  int          sensor_mode_q[$];
  logic [7:0]  exp_q[$];
  logic [7:0]  rx_q[$];
  int          expected_count;
  int          compared_count;
  logic [31:0] rng_state;
  logic [7:0]  lim [0:4];   // Thresholds last committed
  logic [7:0]  last_temp;
  logic [7:0]  last_umid;

  assign dht_bus = sensor_low ? 1'b0 : 1'bz;

  tusca tusca_inst (
    .clock(clock),
    .reset(reset),
    .start(start),
    .definir_config(definir_config),
    .cancelar_definir_config(cancelar_definir_config),
    .rx_serial_config(rx_serial_config),
    .dht_bus(dht_bus),
    .erro_config(erro_config),
    .rele(rele),
    .pwm_ventoinha(pwm_ventoinha),
    .tx_serial(tx_serial),
    .esperando_config(esperando_config)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Errors found");
    $fatal(1, "Simulation stopped at %0t", $time);
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clock);
    #2;
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // Count of limits at or below the temperature
  function automatic nivel_t expected_nivel(input logic [7:0] t, input logic [7:0] l1,
                                            input logic [7:0] l2, input logic [7:0] l3,
                                            input logic [7:0] l4);
    int n;
    n = 0;
    if (t >= l1) n++;
    if (t >= l2) n++;
    if (t >= l3) n++;
    if (t >= l4) n++;
    return nivel_t'(n);
  endfunction

  function automatic logic expected_rele(input logic [7:0] umid, input logic [7:0] lu);
    return umid >= lu;
  endfunction

  function automatic int expected_pwm_high(input nivel_t n);
    return int'(n) * `TUSCA_PWM_PERIOD / 4;
  endfunction

  // Sensor word and expected tx_serial bytes for one measurement
  task automatic queue_reading(input int mode, input logic [7:0] temp, input logic [7:0] umid);
    logic [7:0] umid_dec;
    logic [7:0] temp_dec;
    logic [7:0] soma;
    umid_dec = 8'(next_random() % 10);
    temp_dec = 8'(next_random() % 10);
    soma = umid + umid_dec + temp + temp_dec;
    if (mode == mode_bad_sum) begin
      soma = soma + 8'd1;
    end
    sensor_word_q.push_back({umid, umid_dec, temp, temp_dec, soma});
    sensor_mode_q.push_back(mode);
    if (mode == mode_good) begin
      exp_q.push_back(temp);
      exp_q.push_back(umid);
      exp_q.push_back(8'(expected_nivel(temp, lim[0], lim[1], lim[2], lim[3])));
      expected_count += 3;
      last_temp = temp;
      last_umid = umid;
    end else begin
      exp_q.push_back(8'hEE);
      expected_count += 1;
    end
  endtask

  task automatic wait_for_frames();
    while (compared_count < expected_count) begin
      @(negedge clock);
    end
  endtask

  task automatic check_actuators();
    int   high_count;
    int   want_high;
    logic want_rele;
    high_count = 0;
    want_rele = expected_rele(last_umid, lim[4]);
    want_high = expected_pwm_high(expected_nivel(last_temp, lim[0], lim[1], lim[2], lim[3]));
    wait_cycles(`TUSCA_PWM_PERIOD + 2);   // Duty is latched at the period start
    repeat (`TUSCA_PWM_PERIOD) begin
      @(negedge clock);
      if (pwm_ventoinha) begin
        high_count++;
      end
    end
    assert (rele === want_rele) else
      report_failure($sformatf("[FAIL] rele: got 0x%0h expected 0x%0h", rele, want_rele));
    assert (high_count == want_high) else
      report_failure($sformatf("[FAIL] pwm_ventoinha high count: got 0x%0h expected 0x%0h",
                               high_count, want_high));
  endtask

  task automatic run_measurement(input int mode, input logic [7:0] temp,
                                 input logic [7:0] umid);
    queue_reading(mode, temp, umid);
    wait_for_frames();
    check_actuators();
  endtask

  task automatic run_random_measurement();
    logic [7:0] temp;
    logic [7:0] umid;
    temp = 8'(10 + next_random() % 35);
    umid = 8'(40 + next_random() % 50);
    run_measurement(mode_good, temp, umid);
  endtask

  task automatic wait_config_level(input logic level, input int max_cycles);
    int waited;
    waited = 0;
    while (esperando_config !== level && waited < max_cycles) begin
      @(negedge clock);
      waited++;
    end
    assert (esperando_config === level) else
      report_failure($sformatf("esperando_config did not go to %0b within %0d cycles",
                               level, max_cycles));
  endtask

  task automatic enter_config();
    wait_cycles(1);
    definir_config = 1'b1;
    wait_cycles(3);
    definir_config = 1'b0;
    wait_config_level(1'b1, 8);
  endtask

  task automatic send_uart_byte(input logic [7:0] value);
    int i;
    rx_serial_config = 1'b0;              // Start bit
    wait_cycles(bit_cycles);
    for (i = 0; i < 8; i++) begin
      rx_serial_config = value[i];
      wait_cycles(bit_cycles);
    end
    rx_serial_config = 1'b1;
    wait_cycles(bit_cycles);
  endtask

  task automatic send_config_frame(input logic [7:0] l1, input logic [7:0] l2,
                                   input logic [7:0] l3, input logic [7:0] l4,
                                   input logic [7:0] lu, input logic bad_sum);
    logic [7:0] soma;
    logic       valid;
    soma = l1 + l2 + l3 + l4 + lu;
    if (bad_sum) begin
      soma = soma ^ 8'h5A;
    end
    valid = !bad_sum && (l1 < l2) && (l2 < l3) && (l3 < l4);
    wait_cycles(1);
    send_uart_byte(l1);
    send_uart_byte(l2);
    send_uart_byte(l3);
    send_uart_byte(l4);
    send_uart_byte(lu);
    send_uart_byte(soma);
    wait_config_level(1'b0, bit_cycles);
    assert (erro_config === !valid) else
      report_failure($sformatf("[FAIL] erro_config: got 0x%0h expected 0x%0h",
                               erro_config, !valid));
    if (valid) begin
      lim[0] = l1;
      lim[1] = l2;
      lim[2] = l3;
      lim[3] = l4;
      lim[4] = lu;
    end
  endtask

  task automatic cancel_config();
    logic erro_before;
    erro_before = erro_config;
    enter_config();
    wait_cycles(20);
    cancelar_definir_config = 1'b1;
    wait_cycles(3);
    cancelar_definir_config = 1'b0;
    wait_config_level(1'b0, 8);
    assert (erro_config === erro_before) else
      report_failure($sformatf("[FAIL] erro_config: got 0x%0h expected 0x%0h",
                               erro_config, erro_before));
  endtask

  task automatic hold_bus(input logic level, input int cycles);
    sensor_low = !level;
    wait_cycles(cycles);
  endtask

  initial begin : sensor_model
    logic [39:0] word;
    int          mode;
    int          i;
    @(negedge reset);
    forever begin
      @(negedge dht_bus);                 // Master start pulse
      wait (dht_bus === 1'b1);
      assert (sensor_mode_q.size() > 0) else
        report_failure("Sensor start pulse arrived with no reading queued");
      word = sensor_word_q.pop_front();
      mode = sensor_mode_q.pop_front();
      if (mode != mode_silent) begin
        wait_cycles(4);
        hold_bus(1'b0, 8);                // Response low and high
        hold_bus(1'b1, 8);
        for (i = 39; i >= 0; i--) begin
          hold_bus(1'b0, 5);
          hold_bus(1'b1, word[i] ? 20 : 5);
        end
        hold_bus(1'b0, 5);                // Ends the last high phase
        sensor_low = 1'b0;
      end
    end
  end

  initial begin : tx_monitor
    logic [7:0] rx_byte;
    int         i;
    @(negedge reset);
    forever begin
      @(negedge tx_serial);
      repeat (bit_cycles / 2) @(negedge clock);
      assert (tx_serial === 1'b0) else
        report_failure("Start bit on tx_serial ended before mid-bit");
      for (i = 0; i < 8; i++) begin
        repeat (bit_cycles) @(negedge clock);
        rx_byte[i] = tx_serial;
      end
      repeat (bit_cycles) @(negedge clock);
      assert (tx_serial === 1'b1) else
        report_failure("Stop bit on tx_serial was low");
      rx_q.push_back(rx_byte);
    end
  end

  initial begin : compare_frames
    logic [7:0] got;
    logic [7:0] want;
    forever begin
      @(negedge clock);
      while (rx_q.size() > 0) begin
        got = rx_q.pop_front();
        assert (exp_q.size() > 0) else
          report_failure($sformatf("Unexpected byte 0x%02h on tx_serial", got));
        want = exp_q.pop_front();
        assert (got == want) else
          report_failure($sformatf("[FAIL] tx_serial byte %0d: got 0x%02h expected 0x%02h",
                                   compared_count, got, want));
        compared_count++;
      end
    end
  end

  initial begin : watchdog
    repeat (watchdog_cycles) @(posedge clock);
    report_failure("Watchdog timeout, the DUT stopped producing frames");
  end

  initial begin : stimulus
    reset = 1'b1;
    start = 1'b0;
    definir_config = 1'b0;
    cancelar_definir_config = 1'b0;
    rx_serial_config = 1'b1;
    sensor_low = 1'b0;
    expected_count = 0;
    compared_count = 0;
    rng_state = 32'h36c88b39;
    lim[0] = 8'(`TUSCA_LIM_TEMP1);
    lim[1] = 8'(`TUSCA_LIM_TEMP2);
    lim[2] = 8'(`TUSCA_LIM_TEMP3);
    lim[3] = 8'(`TUSCA_LIM_TEMP4);
    lim[4] = 8'(`TUSCA_LIM_UMIDADE);
    last_temp = 8'd0;
    last_umid = 8'd0;
    wait_cycles(2);
    reset = 1'b0;

    // Default thresholds, levels at the limit edges and random readings
    queue_reading(mode_good, 8'd27, 8'd55);
    wait_cycles(2);
    start = 1'b1;
    wait_cycles(2);
    start = 1'b0;
    wait_for_frames();
    check_actuators();
    run_measurement(mode_good, 8'd20, 8'd70);
    run_measurement(mode_good, 8'd35, 8'd69);
    repeat (4) run_random_measurement();

    // Bad checksum, then silent sensor, each followed by a good reading
    run_measurement(mode_good, 8'd22, 8'd50);
    run_measurement(mode_bad_sum, 8'd33, 8'd80);
    run_random_measurement();
    run_measurement(mode_silent, 8'd0, 8'd0);
    run_measurement(mode_good, 8'd24, 8'd75);

    enter_config();
    send_config_frame(8'd15, 8'd22, 8'd28, 8'd40, 8'd55, 1'b0);
    run_measurement(mode_good, 8'd22, 8'd60);
    run_random_measurement();
    run_measurement(mode_good, 8'd28, 8'd56);

    // Rejected frames keep the thresholds
    enter_config();
    send_config_frame(8'd10, 8'd20, 8'd30, 8'd40, 8'd50, 1'b1);
    check_actuators();
    enter_config();
    send_config_frame(8'd30, 8'd25, 8'd35, 8'd40, 8'd60, 1'b0);
    check_actuators();

    cancel_config();
    check_actuators();
    run_measurement(mode_good, 8'd41, 8'd54);

    $display("No errors");
    $finish;
  end

endmodule

//--- vlog.f
+incdir+common
common/tusca_pkg.sv
rtl/tusca_uc.sv
dht11/dht11_interface.sv
serial/uart_rx.sv
serial/measurement_sender.sv
rtl/config_manager.sv
rtl/climate_actuator.sv
rtl/tusca.sv
tests/tb_tusca.sv
